// ==== led_panel.f ====
+incdir+sim
logic/led_panel_pkg.sv
logic/led_panel_regs_pkg.sv
logic/pixel_fetch_if.sv
logic/timeout.sv
logic/framebuffer_ram.sv
logic/framebuffer_fetch.sv
logic/panel_scan.sv
logic/apb_panel_regs.sv
logic/led_panel.sv
sim/led_panel_tb.sv

// ==== sim/led_panel_model.svh ====
`ifndef LED_PANEL_MODEL_SVH
`define LED_PANEL_MODEL_SVH

// reference image and panel mapping, included inside the testbench module

// panel geometry as seen from the host
localparam int SCREEN_COLS = 64;
localparam int HALF_ROWS   = 16;
localparam int MODEL_PLANES = 5;
localparam int PIXEL_COUNT = 2 * HALF_ROWS * SCREEN_COLS;

// lowest shown bit of each rgb565 field
localparam int MODEL_RED_LSB   = 11;
localparam int MODEL_GREEN_LSB = 6;
localparam int MODEL_BLUE_LSB  = 0;

// copy of every word written into the framebuffer
logic [15:0] image [PIXEL_COUNT];

// stored index is half, then row, then stored column
function automatic int stored_index(input int half, input int row, input int stored_col);
    return half * HALF_ROWS * SCREEN_COLS + row * SCREEN_COLS + stored_col;
endfunction

// expected {r1, g1, b1, r2, g2, b2} for one screen column of one row and plane
function automatic logic [5:0] expected_bits(input int col, input int row, input int plane);
    logic [15:0] top;
    logic [15:0] bottom;
    int          stored_col;
    // panel is mirrored left to right
    stored_col = SCREEN_COLS - 1 - col;
    // half 1 feeds the upper shift chain, half 0 the lower one
    top    = image[stored_index(1, row, stored_col)];
    bottom = image[stored_index(0, row, stored_col)];
    return {top[MODEL_RED_LSB + plane], top[MODEL_GREEN_LSB + plane],
            top[MODEL_BLUE_LSB + plane], bottom[MODEL_RED_LSB + plane],
            bottom[MODEL_GREEN_LSB + plane], bottom[MODEL_BLUE_LSB + plane]};
endfunction

`endif

// ==== sim/led_panel_tb.sv ====
`timescale 1ns/1ps

module led_panel_tb;

    `include "led_panel_model.svh"

    localparam int CLK_PERIOD    = 100;
    localparam int SEED          = 32'h867e_86b8;
    localparam int CTRL_ADDR     = 0;
    localparam int STATUS_ADDR   = 4;
    localparam int PIXEL_ADDR    = 4096;
    localparam int PLANE_UNIT    = 32;
    // start, four fetch cycles, clock high, clock low
    localparam int COLUMN_CYCLES = 6;
    localparam int IDLE_CYCLES   = 500;
    localparam int FRAME_CYCLES  = HALF_ROWS * (MODEL_PLANES * (SCREEN_COLS * COLUMN_CYCLES + 2)
                                   + PLANE_UNIT * ((1 << MODEL_PLANES) - 1));
    localparam int SETUP_CYCLES  = PIXEL_COUNT * 3 + IDLE_CYCLES + 2000;
    localparam longint WATCHDOG_NS = longint'(2 * FRAME_CYCLES + SETUP_CYCLES) * CLK_PERIOD;

    logic        clk_in = 1'b0;
    logic        reset;
    logic [13:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        r1, g1, b1, r2, g2, b2;
    logic [3:0]  row_select;
    logic        panel_clk;
    logic        latch;
    logic        blank;

    // scan position the monitor expects next
    int trk_col;
    int trk_row;
    int trk_plane;
    int latch_count;
    int fail_count;
    bit monitor_on;
    bit expect_idle;

    led_panel i_dut (
        .clk_in(clk_in), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .r1(r1), .g1(g1), .b1(b1), .r2(r2), .g2(g2), .b2(b2),
        .row_select(row_select), .panel_clk(panel_clk), .latch(latch), .blank(blank)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_count++;
            $display("error: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // setup phase, then access phase, sampled mid cycle before the completing edge
    task automatic apb_access(input logic [13:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk_in);
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        @(negedge clk_in);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        rdata = prdata;
        err   = pslverr;
        check_value("pready", pready, 1);
        @(negedge clk_in);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [13:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b1, data, rdata, err);
        check_value("pslverr", err, exp_err);
    endtask

    task automatic apb_read(input logic [13:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b0, 32'h0, rdata, err);
        check_value("pslverr", err, exp_err);
        // read data only means something on a good access
        if (!exp_err) begin
            check_value("prdata", rdata, exp_data);
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk_in) begin : panel_monitor
        logic [5:0] exp_bits;
        if (monitor_on) begin
            if (expect_idle) begin
                check_value("panel_clk while idle", panel_clk, 0);
                check_value("latch while idle", latch, 0);
                check_value("blank while idle", blank, 1);
            end
            if (panel_clk) begin
                exp_bits = expected_bits(trk_col, trk_row, trk_plane);
                check_value("r1", r1, exp_bits[5]);
                check_value("g1", g1, exp_bits[4]);
                check_value("b1", b1, exp_bits[3]);
                check_value("r2", r2, exp_bits[2]);
                check_value("g2", g2, exp_bits[1]);
                check_value("b2", b2, exp_bits[0]);
                trk_col++;
            end
            if (latch) begin
                check_value("blank at latch", blank, 1);
                check_value("row_select", row_select, trk_row);
                check_value("columns before latch", trk_col, SCREEN_COLS);
                trk_col = 0;
                latch_count++;
                // planes step inside rows
                if (trk_plane == MODEL_PLANES - 1) begin
                    trk_plane = 0;
                    trk_row   = (trk_row + 1) % HALF_ROWS;
                end else begin
                    trk_plane++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired: the scan did not finish a frame in time");
        $display("Test failures found");
        $fatal(1);
    end

    initial begin : stimulus
        logic [31:0] data;
        void'($urandom(SEED));
        reset       = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        trk_col     = 0;
        trk_row     = 0;
        trk_plane   = 0;
        latch_count = 0;
        fail_count  = 0;
        monitor_on  = 1'b0;
        expect_idle = 1'b1;
        repeat (2) @(negedge clk_in);
        reset = 1'b0;

        // panel outputs right after reset
        check_value("blank", blank, 1);
        check_value("panel_clk", panel_clk, 0);
        check_value("latch", latch, 0);
        check_value("row_select", row_select, 0);
        check_value("colour outputs", {r1, g1, b1, r2, g2, b2}, 0);
        monitor_on = 1'b1;

        // register reset values, ctrl upper bits are not stored
        apb_read(CTRL_ADDR, 0, 0);
        apb_read(STATUS_ADDR, 0, 0);
        apb_write(CTRL_ADDR, $urandom & 32'hffff_fffe, 0);
        apb_read(CTRL_ADDR, 0, 0);

        // error responses
        data = 8 + 4 * ($urandom % 1000);
        apb_write(data[13:0], $urandom, 1);
        apb_read(data[13:0], 0, 1);
        apb_write(STATUS_ADDR, $urandom, 1);
        apb_read(STATUS_ADDR, 0, 0);
        data = PIXEL_ADDR + 4 * ($urandom % PIXEL_COUNT);
        apb_read(data[13:0], 0, 1);
        apb_write(data[13:0] + 14'd2, $urandom, 1);

        // fill the whole framebuffer, upper data bits are ignored
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            image[i] = 16'($urandom);
            data     = PIXEL_ADDR + 4 * i;
            apb_write(data[13:0], {16'($urandom), image[i]}, 0);
        end

        // one full frame with the scan running
        expect_idle = 1'b0;
        apb_write(CTRL_ADDR, $urandom | 32'h1, 0);
        apb_read(CTRL_ADDR, 1, 0);
        wait (latch_count == MODEL_PLANES * HALF_ROWS);
        apb_write(CTRL_ADDR, 0, 0);

        // last plane finishes its on time, then the scan parks
        while (blank !== 1'b1) begin
            @(negedge clk_in);
        end
        expect_idle = 1'b1;
        apb_read(STATUS_ADDR, 1, 0);
        apb_read(CTRL_ADDR, 0, 0);
        repeat (IDLE_CYCLES) @(negedge clk_in);
        check_value("latch count", latch_count, MODEL_PLANES * HALF_ROWS);

        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== logic/led_panel.sv ====
`timescale 1ns/1ps

module led_panel (
    input  logic                                         clk_in,
    input  logic                                         reset,
    input  logic [led_panel_regs_pkg::APB_ADDR_BITS-1:0] paddr,
    input  logic                                         psel,
    input  logic                                         penable,
    input  logic                                         pwrite,
    input  logic [led_panel_regs_pkg::APB_DATA_BITS-1:0] pwdata,
    output logic [led_panel_regs_pkg::APB_DATA_BITS-1:0] prdata,
    output logic                                         pready,
    output logic                                         pslverr,
    output logic                                         r1,
    output logic                                         g1,
    output logic                                         b1,
    output logic                                         r2,
    output logic                                         g2,
    output logic                                         b2,
    output logic [led_panel_pkg::ROW_BITS-1:0]           row_select,
    output logic                                         panel_clk,
    output logic                                         latch,
    output logic                                         blank
);

    logic                                    enable;
    logic                                    frame_done;
    logic                                    wr_en;
    logic [led_panel_pkg::RAM_ADDR_BITS-1:0] wr_addr;
    logic [led_panel_pkg::PIXEL_BITS-1:0]    wr_data;
    logic [led_panel_pkg::RAM_ADDR_BITS-1:0] ram_address;
    logic                                    ram_clk_enable;
    logic [led_panel_pkg::PIXEL_BITS-1:0]    ram_data;

    // request and pixel pair between scanner and fetcher
    pixel_fetch_if pix ();

    apb_panel_regs i_regs (
        .reset     (reset),
        .clk_in    (clk_in),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .enable    (enable),
        .frame_done(frame_done),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    framebuffer_ram i_ram (
        .clk_in (clk_in),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_en  (ram_clk_enable),
        .rd_addr(ram_address),
        .rd_data(ram_data)
    );

    framebuffer_fetch i_fetch (
        .reset         (reset),
        .clk_in        (clk_in),
        .pix           (pix.fetcher),
        .ram_address   (ram_address),
        .ram_clk_enable(ram_clk_enable),
        .ram_data      (ram_data)
    );

    panel_scan i_scan (
        .reset     (reset),
        .clk_in    (clk_in),
        .enable    (enable),
        .pix       (pix.scanner),
        .r1        (r1),
        .g1        (g1),
        .b1        (b1),
        .r2        (r2),
        .g2        (g2),
        .b2        (b2),
        .row_select(row_select),
        .panel_clk (panel_clk),
        .latch     (latch),
        .blank     (blank),
        .frame_done(frame_done)
    );

endmodule

// ==== logic/apb_panel_regs.sv ====
`timescale 1ns/1ps

module apb_panel_regs (
    input  logic                                         reset,
    input  logic                                         clk_in,
    input  logic [led_panel_regs_pkg::APB_ADDR_BITS-1:0] paddr,
    input  logic                                         psel,
    input  logic                                         penable,
    input  logic                                         pwrite,
    input  logic [led_panel_regs_pkg::APB_DATA_BITS-1:0] pwdata,
    output logic [led_panel_regs_pkg::APB_DATA_BITS-1:0] prdata,
    output logic                                         pready,
    output logic                                         pslverr,
    output logic                                         enable,
    input  logic                                         frame_done,
    output logic                                         wr_en,
    output logic [led_panel_pkg::RAM_ADDR_BITS-1:0]      wr_addr,
    output logic [led_panel_pkg::PIXEL_BITS-1:0]         wr_data
);

    localparam int AW = led_panel_regs_pkg::APB_ADDR_BITS;

    led_panel_regs_pkg::reg_sel_t                        reg_sel;
    logic                                                access;
    logic                                                in_window;
    logic [AW-1:0]                                       pixel_offset;
    logic [led_panel_regs_pkg::FRAME_COUNT_BITS-1:0]     frame_count;

    // byte offset into the pixel window, word aligned slots
    assign pixel_offset = paddr - AW'(led_panel_regs_pkg::PIXEL_BASE);
    assign in_window    = (paddr >= AW'(led_panel_regs_pkg::PIXEL_BASE)) &&
                          (pixel_offset < AW'(led_panel_regs_pkg::PIXEL_WINDOW_BYTES));

    always_comb begin
        if (paddr == AW'(led_panel_regs_pkg::REG_CTRL)) begin
            reg_sel = led_panel_regs_pkg::sel_ctrl;
        end else if (paddr == AW'(led_panel_regs_pkg::REG_STATUS)) begin
            reg_sel = led_panel_regs_pkg::sel_status;
        end else if (in_window && paddr[1:0] == 2'b00) begin
            reg_sel = led_panel_regs_pkg::sel_pixel;
        end else begin
            reg_sel = led_panel_regs_pkg::sel_none;
        end
    end

    // zero wait states, access phase is psel with penable
    assign access = psel && penable;
    assign pready = 1'b1;

    // status is read only, pixel window is write only
    always_comb begin
        pslverr = 1'b0;
        if (access) begin
            case (reg_sel)
                led_panel_regs_pkg::sel_status: pslverr = pwrite;
                led_panel_regs_pkg::sel_pixel:  pslverr = !pwrite;
                led_panel_regs_pkg::sel_none:   pslverr = 1'b1;
                default:                        pslverr = 1'b0;
            endcase
        end
    end

    always_comb begin
        prdata = '0;
        case (reg_sel)
            led_panel_regs_pkg::sel_ctrl:   prdata[0] = enable;
            led_panel_regs_pkg::sel_status: prdata[15:0] = frame_count;
            default:                        prdata = '0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            enable      <= 1'b0;
            frame_count <= '0;
            wr_en       <= 1'b0;
        end else begin
            wr_en <= access && pwrite && (reg_sel == led_panel_regs_pkg::sel_pixel);
            if (access && pwrite && reg_sel == led_panel_regs_pkg::sel_ctrl) begin
                enable <= pwdata[0];
            end
            // wraps after 65535 frames
            if (frame_done) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    // ram write lands one cycle after the access phase
    always_ff @(posedge clk_in) begin
        wr_addr <= pixel_offset[led_panel_pkg::RAM_ADDR_BITS+1:2];
        wr_data <= pwdata[led_panel_pkg::PIXEL_BITS-1:0];
    end

    a_penable_in_psel : assert property (
        @(posedge clk_in) disable iff (reset) penable |-> psel
    );

endmodule

// ==== logic/panel_scan.sv ====
`timescale 1ns/1ps

module panel_scan (
    input  logic                               reset,
    input  logic                               clk_in,
    input  logic                               enable,
    pixel_fetch_if.scanner                     pix,
    output logic                               r1,
    output logic                               g1,
    output logic                               b1,
    output logic                               r2,
    output logic                               g2,
    output logic                               b2,
    output logic [led_panel_pkg::ROW_BITS-1:0] row_select,
    output logic                               panel_clk,
    output logic                               latch,
    output logic                               blank,
    output logic                               frame_done
);

    localparam int R = led_panel_pkg::RED_LSB;
    localparam int G = led_panel_pkg::GREEN_LSB;
    localparam int B = led_panel_pkg::BLUE_LSB;

    led_panel_pkg::scan_state_t                state;
    logic [led_panel_pkg::ROW_BITS-1:0]       row;
    logic [led_panel_pkg::PLANE_BITS-1:0]     plane;
    logic [led_panel_pkg::COL_BITS-1:0]       column;
    logic [led_panel_pkg::ON_TIME_BITS-1:0]   on_time;

    assign pix.column_address = column;
    assign pix.row_address    = row;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state                <= led_panel_pkg::scan_idle;
            row                  <= '0;
            plane                <= '0;
            column               <= '0;
            on_time              <= '0;
            pix.pixel_load_start <= 1'b0;
            {r1, g1, b1}         <= 3'b000;
            {r2, g2, b2}         <= 3'b000;
            row_select           <= '0;
            panel_clk            <= 1'b0;
            latch                <= 1'b0;
            blank                <= 1'b1;
            frame_done           <= 1'b0;
        end else begin
            // strobes default low
            pix.pixel_load_start <= 1'b0;
            frame_done           <= 1'b0;
            case (state)
                led_panel_pkg::scan_idle: begin
                    if (enable) begin
                        pix.pixel_load_start <= 1'b1;
                        state                <= led_panel_pkg::scan_fetch;
                    end
                end
                led_panel_pkg::scan_fetch: begin
                    // present one bit of the current plane from each half
                    if (pix.pixel_valid) begin
                        r1        <= pix.rgb565_top[R + plane];
                        g1        <= pix.rgb565_top[G + plane];
                        b1        <= pix.rgb565_top[B + plane];
                        r2        <= pix.rgb565_bottom[R + plane];
                        g2        <= pix.rgb565_bottom[G + plane];
                        b2        <= pix.rgb565_bottom[B + plane];
                        panel_clk <= 1'b1;
                        state     <= led_panel_pkg::scan_shift;
                    end
                end
                led_panel_pkg::scan_shift: begin
                    // clock low again while the next column is fetched
                    panel_clk <= 1'b0;
                    column    <= column + 1'b1;
                    if (column == led_panel_pkg::COL_BITS'(led_panel_pkg::PIXEL_WIDTH - 1)) begin
                        latch      <= 1'b1;
                        row_select <= row;
                        state      <= led_panel_pkg::scan_latch;
                    end else begin
                        pix.pixel_load_start <= 1'b1;
                        state                <= led_panel_pkg::scan_fetch;
                    end
                end
                led_panel_pkg::scan_latch: begin
                    // light the row for the binary weight of this plane
                    latch   <= 1'b0;
                    blank   <= 1'b0;
                    on_time <= led_panel_pkg::ON_TIME_BITS'(
                        (led_panel_pkg::PLANE_UNIT << plane) - 1);
                    state   <= led_panel_pkg::scan_display;
                end
                led_panel_pkg::scan_display: begin
                    if (on_time != '0) begin
                        on_time <= on_time - 1'b1;
                    end else begin
                        blank <= 1'b1;
                        // planes step inside rows
                        if (plane == led_panel_pkg::PLANE_BITS'(led_panel_pkg::NUM_PLANES - 1)) begin
                            plane <= '0;
                            row   <= row + 1'b1;
                            if (row == led_panel_pkg::ROW_BITS'(led_panel_pkg::PIXEL_HALFHEIGHT - 1)) begin
                                frame_done <= 1'b1;
                            end
                        end else begin
                            plane <= plane + 1'b1;
                        end
                        // enable is only sampled between planes
                        if (enable) begin
                            pix.pixel_load_start <= 1'b1;
                            state                <= led_panel_pkg::scan_fetch;
                        end else begin
                            state <= led_panel_pkg::scan_idle;
                        end
                    end
                end
                default: state <= led_panel_pkg::scan_idle;
            endcase
        end
    end

    // latching a lit row would flash the half-shifted data
    a_latch_blanked : assert property (
        @(posedge clk_in) disable iff (reset) latch |-> blank
    );

endmodule

// ==== logic/framebuffer_fetch.sv ====
`timescale 1ns/1ps

module framebuffer_fetch (
    input  logic                                    reset,
    input  logic                                    clk_in,
    pixel_fetch_if.fetcher                          pix,
    output logic [led_panel_pkg::RAM_ADDR_BITS-1:0] ram_address,
    output logic                                    ram_clk_enable,
    input  logic [led_panel_pkg::PIXEL_BITS-1:0]    ram_data
);

    logic [led_panel_pkg::LOAD_BITS-1:0] load_counter;
    logic                                load_running;
    logic                                half_address;

    // counts 3, 2, 1 after the start pulse, then rests at 0
    timeout #(
        .COUNTER_WIDTH(led_panel_pkg::LOAD_BITS)
    ) i_load_timeout (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (pix.pixel_load_start),
        .value  (led_panel_pkg::LOAD_BITS'(led_panel_pkg::LOAD_CYCLES)),
        .counter(load_counter),
        .running(load_running)
    );

    // ram only clocks while a fetch is in flight
    assign ram_clk_enable = load_running;

    // bottom half (half 0) addressed at count 3, top half from count 2 on
    assign half_address = (load_counter != 2'd3);

    // panel is mirrored, screen column c lives at stored column 63 - c
    assign ram_address = {half_address, pix.row_address, ~pix.column_address};

    // read data lags the address by one cycle
    // count 2 sees the bottom word, count 1 sees the top word
    always_ff @(posedge clk_in) begin
        if (load_counter == 2'd2) begin
            pix.rgb565_bottom <= ram_data;
        end
        if (load_counter == 2'd1) begin
            pix.rgb565_top <= ram_data;
        end
    end

    // valid lands on count 0, four cycles after start
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pix.pixel_valid <= 1'b0;
        end else begin
            pix.pixel_valid <= (load_counter == 2'd1);
        end
    end

    // one fetch at a time, so never back to back
    a_valid_single : assert property (
        @(posedge clk_in) disable iff (reset) pix.pixel_valid |=> !pix.pixel_valid
    );

endmodule

// ==== logic/framebuffer_ram.sv ====
`timescale 1ns/1ps

module framebuffer_ram (
    input  logic                                    clk_in,
    input  logic                                    wr_en,
    input  logic [led_panel_pkg::RAM_ADDR_BITS-1:0] wr_addr,
    input  logic [led_panel_pkg::PIXEL_BITS-1:0]    wr_data,
    input  logic                                    rd_en,
    input  logic [led_panel_pkg::RAM_ADDR_BITS-1:0] rd_addr,
    output logic [led_panel_pkg::PIXEL_BITS-1:0]    rd_data
);

    localparam int DEPTH = 2 ** led_panel_pkg::RAM_ADDR_BITS;

    // one rgb565 word per pixel, both halves of the panel
    logic [led_panel_pkg::PIXEL_BITS-1:0] mem [DEPTH];

    // host write port
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // scan read port, data holds while rd_en is low
    always_ff @(posedge clk_in) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== logic/timeout.sv ====
`timescale 1ns/1ps

module timeout #(
    parameter int COUNTER_WIDTH = 2
) (
    input  logic                     reset,
    input  logic                     clk_in,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    // load on start, then count down and stop at zero
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    assign running = (counter != '0);

    // the requester must wait for the previous run to finish
    a_no_restart : assert property (
        @(posedge clk_in) disable iff (reset) start |-> !running
    );

endmodule

// ==== logic/pixel_fetch_if.sv ====
`timescale 1ns/1ps

interface pixel_fetch_if;

    // request side, owned by the scanner
    logic [led_panel_pkg::COL_BITS-1:0]   column_address;
    logic [led_panel_pkg::ROW_BITS-1:0]   row_address;
    logic                                 pixel_load_start;

    // returned pair, valid for one cycle
    logic [led_panel_pkg::PIXEL_BITS-1:0] rgb565_top;
    logic [led_panel_pkg::PIXEL_BITS-1:0] rgb565_bottom;
    logic                                 pixel_valid;

    modport fetcher (
        input  column_address, row_address, pixel_load_start,
        output rgb565_top, rgb565_bottom, pixel_valid
    );

    modport scanner (
        output column_address, row_address, pixel_load_start,
        input  rgb565_top, rgb565_bottom, pixel_valid
    );

endinterface

// ==== logic/led_panel_regs_pkg.sv ====
package led_panel_regs_pkg;

    // pixel window ends at 4096 + 4 * 2047, which needs 14 address bits
    localparam int APB_ADDR_BITS = 14;
    localparam int APB_DATA_BITS = 32;

    // register offsets
    localparam int REG_CTRL   = 0;
    localparam int REG_STATUS = 4;

    // one ram word per 32-bit slot
    localparam int PIXEL_BASE         = 4096;
    localparam int PIXEL_WINDOW_BYTES = 4 * 2048;

    localparam int FRAME_COUNT_BITS = 16;

    typedef enum logic [1:0] {
        sel_ctrl,
        sel_status,
        sel_pixel,
        sel_none
    } reg_sel_t;

endpackage

// ==== logic/led_panel_pkg.sv ====
package led_panel_pkg;

    // panel geometry, 64 columns by two halves of 16 rows
    localparam int PIXEL_WIDTH      = 64;
    localparam int PIXEL_HALFHEIGHT = 16;
    localparam int BYTES_PER_PIXEL  = 2;
    localparam int PIXEL_BITS       = BYTES_PER_PIXEL * 8;

    localparam int COL_BITS      = $clog2(PIXEL_WIDTH);
    localparam int ROW_BITS      = $clog2(PIXEL_HALFHEIGHT);
    // ram index is {half, row, column}
    localparam int RAM_ADDR_BITS = 1 + ROW_BITS + COL_BITS;

    // five bit planes per colour, plane p lit PLANE_UNIT << p cycles
    localparam int NUM_PLANES   = 5;
    localparam int PLANE_BITS   = $clog2(NUM_PLANES);
    localparam int PLANE_UNIT   = 32;
    localparam int ON_TIME_BITS = $clog2(PLANE_UNIT << (NUM_PLANES - 1));

    // lowest shown bit of each colour field in rgb565
    localparam int RED_LSB   = 11;
    localparam int GREEN_LSB = 6;
    localparam int BLUE_LSB  = 0;

    // fetch sequencer load value and counter width
    localparam int LOAD_CYCLES = 3;
    localparam int LOAD_BITS   = 2;

    typedef enum logic [2:0] {
        scan_idle,
        scan_fetch,
        scan_shift,
        scan_latch,
        scan_display
    } scan_state_t;

endpackage
